// File: renamePkg.sv
// ===================================================================
// Shared widths, depths and micro-op types of the rename stage.
// Every module of the stage refers to these by scoped names.
// ===================================================================
`default_nettype none

package renamePkg;

    localparam int RENAME_WIDTH = 2;
    localparam int LOG_REG_NUM = 32;
    localparam int PHY_REG_NUM = 64;
    localparam int FREE_LIST_DEPTH = PHY_REG_NUM - LOG_REG_NUM;
    localparam int ACTIVE_LIST_DEPTH = 16;
    localparam int FREE_LIST_PTR_WIDTH = $clog2(FREE_LIST_DEPTH);
    localparam int ACTIVE_LIST_PTR_WIDTH = $clog2(ACTIVE_LIST_DEPTH);

    typedef logic [$clog2(LOG_REG_NUM)-1:0] LogRegNum;
    typedef logic [$clog2(PHY_REG_NUM)-1:0] PhyRegNum;
    typedef logic [ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;
    typedef logic [31:0] PcPath;

    typedef enum logic [1:0] {
        MOP_TYPE_INT    = 2'd0,
        MOP_TYPE_BRANCH = 2'd1,
        MOP_TYPE_MEM    = 2'd2,
        MOP_TYPE_MISC   = 2'd3
    } MopType;

    // Integer and memory ops
    typedef struct packed {
        LogRegNum dst;
        LogRegNum srcA;
        LogRegNum srcB;
    } IntOperand;

    // Branches put the link register last
    typedef struct packed {
        LogRegNum srcA;
        LogRegNum srcB;
        LogRegNum linkDst;
    } BrOperand;

    typedef struct packed {
        logic fence;
        logic [13:0] padding;
    } MiscOperand;

    // One operand word, decoded according to the op kind
    typedef union packed {
        IntOperand intOp;
        BrOperand brOp;
        MiscOperand miscOp;
    } OpOperand;

    typedef struct packed {
        MopType mopType;
        OpOperand operand;
        logic readRegA;
        logic readRegB;
        logic writeReg;
        logic serialized;
        logic isStore;
    } OpInfo;

    typedef struct packed {
        logic valid;
        PcPath pc;
        OpInfo opInfo;
    } DecodedOp;

    typedef struct packed {
        logic valid;
        PcPath pc;
        OpInfo opInfo;
        PhyRegNum phySrcA;
        PhyRegNum phySrcB;
        PhyRegNum phyDst;
        PhyRegNum phyPrevDst;
        ActiveListPtr activeListPtr;
    } RenamedOp;

    typedef struct packed {
        PcPath pc;
        LogRegNum logDst;
        PhyRegNum phyDst;
        PhyRegNum phyPrevDst;
        logic writeReg;
        logic isStore;
        logic serialized;
    } ActiveListEntry;

    typedef struct packed {
        logic valid;
        LogRegNum logDst;
        PhyRegNum phyDst;
        PhyRegNum phyPrevDst;
        logic writeReg;
    } CommitInfo;

endpackage

`default_nettype wire

// File: renameSerializer.sv
// ===================================================================
// Holds the rename stage around serialized ops and fences. Only slot 0
// is examined, since decode sends a serialized op alone.
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module renameSerializer (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic clear,
    input  logic activeListEmpty,
    input  logic storeQueueEmpty,
    input  renamePkg::OpInfo opInfo,
    input  logic valid,
    output logic serialize
);

    typedef enum logic {
        PHASE_NORMAL,
        PHASE_WAIT_OWN
    } Phase;

    Phase phase;
    Phase nextPhase;
    logic isFence;

    assign isFence = (opInfo.mopType == renamePkg::MOP_TYPE_MISC) && opInfo.operand.miscOp.fence;

    always_comb begin
        serialize = 1'b0;
        nextPhase = phase;
        // Own commit and store drain pending
        if (phase == PHASE_WAIT_OWN) begin
            if (!activeListEmpty || !storeQueueEmpty) begin
                serialize = 1'b1;
            end else begin
                nextPhase = PHASE_NORMAL;
            end
        end
        // Older ops must drain first; fences also wait for the store queue
        if (!serialize && valid && opInfo.serialized) begin
            if (!activeListEmpty || (isFence && !storeQueueEmpty)) begin
                serialize = 1'b1;
            end else begin
                nextPhase = PHASE_WAIT_OWN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            phase <= PHASE_NORMAL;
        end else if (!stall) begin
            phase <= nextPhase;
        end
    end

endmodule

`default_nettype wire

// File: renameMapTable.sv
// ===================================================================
// Logical-to-physical map and free list FIFO. Renames one group per
// cycle with bypass from older to younger slots, and takes back one
// freed register per cycle from commit.
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module renameMapTable (
    input  logic clk,
    input  logic rst,
    input  logic [renamePkg::RENAME_WIDTH-1:0] update,
    input  logic [renamePkg::RENAME_WIDTH-1:0] writeReg,
    input  renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logSrcA,
    input  renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logSrcB,
    input  renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logDst,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcA,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcB,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyDst,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyPrevDst,
    output logic allocatable,
    input  logic free,
    input  renamePkg::PhyRegNum freeReg
);

    renamePkg::PhyRegNum mapTable [renamePkg::LOG_REG_NUM];
    renamePkg::PhyRegNum freeList [renamePkg::FREE_LIST_DEPTH];
    logic [renamePkg::FREE_LIST_PTR_WIDTH-1:0] head;
    logic [renamePkg::FREE_LIST_PTR_WIDTH-1:0] tail;
    logic [renamePkg::FREE_LIST_PTR_WIDTH-1:0] popPtr;
    logic [renamePkg::FREE_LIST_PTR_WIDTH:0] count;
    logic [renamePkg::FREE_LIST_PTR_WIDTH:0] popNum;
    logic [renamePkg::RENAME_WIDTH-1:0] alloc;

    assign allocatable = count >= renamePkg::RENAME_WIDTH;

    // Slots that write take consecutive entries from the head
    always_comb begin
        popPtr = head;
        popNum = '0;
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            alloc[i] = update[i] && writeReg[i];
            phyDst[i] = freeList[popPtr];
            if (alloc[i]) begin
                popPtr = popPtr + 1'b1;
                popNum = popNum + 1'b1;
            end
        end
    end

    // Table lookup, then bypass from older slots of the same group
    always_comb begin
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            phySrcA[i] = mapTable[logSrcA[i]];
            phySrcB[i] = mapTable[logSrcB[i]];
            phyPrevDst[i] = mapTable[logDst[i]];
            for (int j = 0; j < i; j++) begin
                if (writeReg[j] && logDst[j] == logSrcA[i]) begin
                    phySrcA[i] = phyDst[j];
                end
                if (writeReg[j] && logDst[j] == logSrcB[i]) begin
                    phySrcB[i] = phyDst[j];
                end
                if (writeReg[j] && logDst[j] == logDst[i]) begin
                    phyPrevDst[i] = phyDst[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, remaining registers free in order
            for (int i = 0; i < renamePkg::LOG_REG_NUM; i++) begin
                mapTable[i] <= renamePkg::PhyRegNum'(i);
            end
            for (int i = 0; i < renamePkg::FREE_LIST_DEPTH; i++) begin
                freeList[i] <= renamePkg::PhyRegNum'(renamePkg::LOG_REG_NUM + i);
            end
            head <= '0;
            tail <= '0;
            count <= (renamePkg::FREE_LIST_PTR_WIDTH + 1)'(renamePkg::FREE_LIST_DEPTH);
        end else begin
            // Younger slot wins on the same destination
            for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
                if (alloc[i]) begin
                    mapTable[logDst[i]] <= phyDst[i];
                end
            end
            if (free) begin
                freeList[tail] <= freeReg;
                tail <= tail + 1'b1;
            end
            head <= popPtr;
            count <= count - popNum + {{renamePkg::FREE_LIST_PTR_WIDTH{1'b0}}, free};
        end
    end

endmodule

`default_nettype wire

// File: activeList.sv
// ===================================================================
// In-order buffer of renamed ops. Rename pushes up to one group per
// cycle at the tail, and each commit strobe retires the head entry.
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module activeList (
    input  logic clk,
    input  logic rst,
    input  logic [renamePkg::RENAME_WIDTH-1:0] push,
    input  renamePkg::ActiveListEntry [renamePkg::RENAME_WIDTH-1:0] pushData,
    output renamePkg::ActiveListPtr [renamePkg::RENAME_WIDTH-1:0] pushedPtr,
    output logic allocatable,
    output logic empty,
    input  logic commit,
    output renamePkg::CommitInfo committed,
    output logic free,
    output renamePkg::PhyRegNum freeReg
);

    renamePkg::ActiveListEntry entries [renamePkg::ACTIVE_LIST_DEPTH];
    renamePkg::ActiveListPtr head;
    renamePkg::ActiveListPtr tail;
    renamePkg::ActiveListPtr nextTail;
    logic [renamePkg::ACTIVE_LIST_PTR_WIDTH:0] count;
    logic [renamePkg::ACTIVE_LIST_PTR_WIDTH:0] pushNum;
    logic pop;

    assign empty = count == '0;
    assign allocatable =
        count <= renamePkg::ACTIVE_LIST_DEPTH - renamePkg::RENAME_WIDTH;
    assign pop = commit && !empty;

    // Pushing slots fill consecutive entries from the tail
    always_comb begin
        nextTail = tail;
        pushNum = '0;
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            pushedPtr[i] = nextTail;
            if (push[i]) begin
                nextTail = nextTail + 1'b1;
                pushNum = pushNum + 1'b1;
            end
        end
    end

    // Commit view straight from the head entry
    always_comb begin
        committed.valid = pop;
        committed.logDst = entries[head].logDst;
        committed.phyDst = entries[head].phyDst;
        committed.phyPrevDst = entries[head].phyPrevDst;
        committed.writeReg = entries[head].writeReg;
        free = pop && entries[head].writeReg;
        freeReg = entries[head].phyPrevDst;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            if (push[i]) begin
                entries[pushedPtr[i]] <= pushData[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            tail <= nextTail;
            count <= count + pushNum - {{renamePkg::ACTIVE_LIST_PTR_WIDTH{1'b0}}, pop};
        end
    end

endmodule

`default_nettype wire

// File: renameStage.sv
// ===================================================================
// Rename stage: pipeline register from decode, stall decision, and
// assembly of renamed ops from the map table and active list results.
// The serializer for serialized ops and fences lives here.
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module renameStage (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic dispatchStall,
    input  logic storeQueueEmpty,
    input  renamePkg::DecodedOp [renamePkg::RENAME_WIDTH-1:0] decoded,
    output logic upstreamStall,
    output renamePkg::RenamedOp [renamePkg::RENAME_WIDTH-1:0] renamed,
    // Map table
    output logic [renamePkg::RENAME_WIDTH-1:0] update,
    output logic [renamePkg::RENAME_WIDTH-1:0] writeReg,
    output renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logSrcA,
    output renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logSrcB,
    output renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logDst,
    input  renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcA,
    input  renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcB,
    input  renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyDst,
    input  renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyPrevDst,
    input  logic mapAllocatable,
    // Active list
    output logic [renamePkg::RENAME_WIDTH-1:0] alPush,
    output renamePkg::ActiveListEntry [renamePkg::RENAME_WIDTH-1:0] alPushData,
    input  renamePkg::ActiveListPtr [renamePkg::RENAME_WIDTH-1:0] alPushedPtr,
    input  logic alAllocatable,
    input  logic alEmpty
);

    renamePkg::DecodedOp [renamePkg::RENAME_WIDTH-1:0] pipeReg;
    logic [renamePkg::RENAME_WIDTH-1:0] valid;
    logic [renamePkg::RENAME_WIDTH-1:0] isBranch;
    logic bubble;
    logic stall;
    logic serialize;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipeReg <= decoded;
        end
    end

    // Bubble request must not depend on the stall it produces
    always_comb begin
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            valid[i] = pipeReg[i].valid;
        end
        bubble = ((|valid) && (!mapAllocatable || !alAllocatable)) || serialize;
        stall = bubble || dispatchStall;
        upstreamStall = stall;
    end

    renameSerializer serializer_inst (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .clear(clear),
        .activeListEmpty(alEmpty),
        .storeQueueEmpty(storeQueueEmpty),
        .opInfo(pipeReg[0].opInfo),
        .valid(pipeReg[0].valid),
        .serialize(serialize)
    );

    always_comb begin
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            update[i] = valid[i] && !stall && !clear;
            writeReg[i] = valid[i] && pipeReg[i].opInfo.writeReg;

            // Register fields sit in different places for branches
            isBranch[i] = pipeReg[i].opInfo.mopType == renamePkg::MOP_TYPE_BRANCH;
            if (isBranch[i]) begin
                logSrcA[i] = pipeReg[i].opInfo.operand.brOp.srcA;
                logSrcB[i] = pipeReg[i].opInfo.operand.brOp.srcB;
                logDst[i] = pipeReg[i].opInfo.operand.brOp.linkDst;
            end else begin
                logSrcA[i] = pipeReg[i].opInfo.operand.intOp.srcA;
                logSrcB[i] = pipeReg[i].opInfo.operand.intOp.srcB;
                logDst[i] = pipeReg[i].opInfo.operand.intOp.dst;
            end

            alPush[i] = update[i];
            alPushData[i].pc = pipeReg[i].pc;
            alPushData[i].logDst = logDst[i];
            alPushData[i].phyDst = phyDst[i];
            alPushData[i].phyPrevDst = phyPrevDst[i];
            alPushData[i].writeReg = pipeReg[i].opInfo.writeReg;
            alPushData[i].isStore = (pipeReg[i].opInfo.mopType == renamePkg::MOP_TYPE_MEM)
                && pipeReg[i].opInfo.isStore;
            alPushData[i].serialized = pipeReg[i].opInfo.serialized;

            // Valid only in the cycle the slot is allocated
            renamed[i].valid = update[i];
            renamed[i].pc = pipeReg[i].pc;
            renamed[i].opInfo = pipeReg[i].opInfo;
            renamed[i].phySrcA = phySrcA[i];
            renamed[i].phySrcB = phySrcB[i];
            renamed[i].phyDst = phyDst[i];
            renamed[i].phyPrevDst = phyPrevDst[i];
            renamed[i].activeListPtr = alPushedPtr[i];
        end
    end

endmodule

`default_nettype wire

// File: renameTop.sv
// ===================================================================
// Top of the rename block. Connects the rename stage to the map table
// and the active list; decode feeds it and dispatch and commit use it.
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module renameTop (
    input  logic clk,
    input  logic rst,
    input  renamePkg::DecodedOp [renamePkg::RENAME_WIDTH-1:0] decoded,
    input  logic clear,
    input  logic dispatchStall,
    input  logic commit,
    input  logic storeQueueEmpty,
    output logic upstreamStall,
    output renamePkg::RenamedOp [renamePkg::RENAME_WIDTH-1:0] renamed,
    output renamePkg::CommitInfo committed
);

    logic [renamePkg::RENAME_WIDTH-1:0] update;
    logic [renamePkg::RENAME_WIDTH-1:0] writeReg;
    renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logSrcA;
    renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logSrcB;
    renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] logDst;
    renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcA;
    renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcB;
    renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyDst;
    renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyPrevDst;
    logic mapAllocatable;
    logic [renamePkg::RENAME_WIDTH-1:0] alPush;
    renamePkg::ActiveListEntry [renamePkg::RENAME_WIDTH-1:0] alPushData;
    renamePkg::ActiveListPtr [renamePkg::RENAME_WIDTH-1:0] alPushedPtr;
    logic alAllocatable;
    logic alEmpty;
    // Register freed at commit
    logic free;
    renamePkg::PhyRegNum freeReg;

    renameStage renameStage_inst (
        .clk(clk), .rst(rst), .clear(clear),
        .dispatchStall(dispatchStall), .storeQueueEmpty(storeQueueEmpty),
        .decoded(decoded), .upstreamStall(upstreamStall), .renamed(renamed),
        .update(update), .writeReg(writeReg),
        .logSrcA(logSrcA), .logSrcB(logSrcB), .logDst(logDst),
        .phySrcA(phySrcA), .phySrcB(phySrcB), .phyDst(phyDst), .phyPrevDst(phyPrevDst),
        .mapAllocatable(mapAllocatable),
        .alPush(alPush), .alPushData(alPushData), .alPushedPtr(alPushedPtr),
        .alAllocatable(alAllocatable), .alEmpty(alEmpty)
    );

    renameMapTable renameMapTable_inst (
        .clk(clk), .rst(rst), .update(update), .writeReg(writeReg),
        .logSrcA(logSrcA), .logSrcB(logSrcB), .logDst(logDst),
        .phySrcA(phySrcA), .phySrcB(phySrcB), .phyDst(phyDst), .phyPrevDst(phyPrevDst),
        .allocatable(mapAllocatable), .free(free), .freeReg(freeReg)
    );

    activeList activeList_inst (
        .clk(clk), .rst(rst), .push(alPush), .pushData(alPushData),
        .pushedPtr(alPushedPtr), .allocatable(alAllocatable), .empty(alEmpty),
        .commit(commit), .committed(committed), .free(free), .freeReg(freeReg)
    );

endmodule

`default_nettype wire

// File: tbRename.sv
// ======================================================================
// Testbench for the rename block. Drives random groups, commit strobes
// and directed phases for serialized ops, fences, clear and dispatch
// stall, and checks renamed and committed ops against a reference model.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tbRename;

    localparam int NUM_CYCLES = 1500;
    localparam int FULL_LEVEL = renamePkg::ACTIVE_LIST_DEPTH - renamePkg::RENAME_WIDTH;

    logic clk;
    logic rst;
    renamePkg::DecodedOp [renamePkg::RENAME_WIDTH-1:0] decoded;
    logic clear;
    logic dispatchStall;
    logic commit;
    logic storeQueueEmpty;
    logic upstreamStall;
    renamePkg::RenamedOp [renamePkg::RENAME_WIDTH-1:0] renamed;
    renamePkg::CommitInfo committed;

    // Reference model
    renamePkg::PhyRegNum modelMap [renamePkg::LOG_REG_NUM];
    bit inUse [renamePkg::PHY_REG_NUM];
    int outstanding;
    renamePkg::CommitInfo expectQ [$];
    renamePkg::DecodedOp pipeOp [renamePkg::RENAME_WIDTH];
    bit killed [renamePkg::PcPath];
    renamePkg::ActiveListPtr nextAlPtr;
    logic holdSerial;
    logic advance;
    int checkedOps;
    int seed = 32'h51c3;
    renamePkg::PcPath nextPc;

    renameTop renameTop_inst (
        .clk(clk), .rst(rst), .decoded(decoded), .clear(clear),
        .dispatchStall(dispatchStall), .commit(commit), .storeQueueEmpty(storeQueueEmpty),
        .upstreamStall(upstreamStall), .renamed(renamed), .committed(committed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        #((NUM_CYCLES + 8) * 4 * 4);
        $display("Timeout: the stimulus did not complete in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic reportFailure(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    // Register fields by op kind; branches keep the link register last
    task automatic decodeFields(input renamePkg::OpInfo info, output renamePkg::LogRegNum a,
                                output renamePkg::LogRegNum b, output renamePkg::LogRegNum d);
        if (info.mopType == renamePkg::MOP_TYPE_BRANCH) begin
            a = info.operand.brOp.srcA;
            b = info.operand.brOp.srcB;
            d = info.operand.brOp.linkDst;
        end else begin
            a = info.operand.intOp.srcA;
            b = info.operand.intOp.srcB;
            d = info.operand.intOp.dst;
        end
    endtask

    task automatic makeOp(input logic serial, input logic fence,
                          output renamePkg::DecodedOp op);
        logic [31:0] r;
        r = $random(seed);
        op = '0;
        op.valid = 1'b1;
        op.pc = nextPc;
        nextPc = nextPc + 32'd4;
        if (serial) begin
            op.opInfo.mopType = renamePkg::MOP_TYPE_MISC;
            op.opInfo.operand.miscOp.fence = fence;
            op.opInfo.serialized = 1'b1;
        end else begin
            op.opInfo.mopType = renamePkg::MopType'(r[21:20]);
            if (op.opInfo.mopType == renamePkg::MOP_TYPE_MISC) begin
                op.opInfo.mopType = renamePkg::MOP_TYPE_INT;
            end
            op.opInfo.operand = r[14:0];
            op.opInfo.readRegA = r[15];
            op.opInfo.readRegB = r[16];
            op.opInfo.isStore = (op.opInfo.mopType == renamePkg::MOP_TYPE_MEM) && r[19];
            op.opInfo.writeReg = (r[17] || r[18]) && !op.opInfo.isStore;
        end
    endtask

    task automatic makeGroup(input logic allowSerial, input logic forceSerial);
        logic [31:0] r;
        renamePkg::DecodedOp op;
        r = $random(seed);
        decoded = '0;
        if (forceSerial || (allowSerial && r[3:0] == 4'd0)) begin
            // Serialized ops travel alone in slot 0
            makeOp(1'b1, r[4], op);
            decoded[0] = op;
        end else begin
            if (r[7:5] != 3'd0) begin
                makeOp(1'b0, 1'b0, op);
                decoded[0] = op;
            end
            if (r[9:8] != 2'd0) begin
                makeOp(1'b0, 1'b0, op);
                decoded[1] = op;
            end
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < renamePkg::LOG_REG_NUM; i++) begin
            modelMap[i] = renamePkg::PhyRegNum'(i);
        end
        for (int i = 0; i < renamePkg::PHY_REG_NUM; i++) begin
            inUse[i] = (i < renamePkg::LOG_REG_NUM);
        end
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            pipeOp[i] = '0;
        end
        expectQ.delete();
        outstanding = 0;
        nextAlPtr = '0;
        holdSerial = 1'b0;
        advance = 1'b1;
    endtask

    task automatic checkCycle();
        int outNow;
        int freeNow;
        logic anyRenamed;
        logic pipeBusy;
        logic isFence;
        logic serialHeld;
        logic serialWait;
        logic expStall;
        renamePkg::LogRegNum srcA;
        renamePkg::LogRegNum srcB;
        renamePkg::LogRegNum dst;
        renamePkg::CommitInfo expCommit;
        outNow = outstanding;
        freeNow = 0;
        for (int i = 0; i < renamePkg::PHY_REG_NUM; i++) begin
            if (!inUse[i]) begin
                freeNow++;
            end
        end
        anyRenamed = renamed[0].valid || renamed[1].valid;
        pipeBusy = pipeOp[0].valid || pipeOp[1].valid;
        // Own serialized op not yet committed or stores not drained
        serialHeld = holdSerial && (outNow != 0 || !storeQueueEmpty);
        // Slot 0 serialized op waiting for older work
        isFence = pipeOp[0].opInfo.mopType == renamePkg::MOP_TYPE_MISC
            && pipeOp[0].opInfo.operand.miscOp.fence;
        serialWait = pipeOp[0].valid && pipeOp[0].opInfo.serialized
            && (outNow != 0 || (isFence && !storeQueueEmpty));
        expStall = dispatchStall || serialHeld || serialWait
            || (pipeBusy && (outNow > FULL_LEVEL || freeNow < renamePkg::RENAME_WIDTH));
        assert (upstreamStall == expStall)
            else reportFailure($sformatf("upstream stall is %0b with %0d ops in flight",
                                         upstreamStall, outNow));
        assert (!dispatchStall || (upstreamStall && !anyRenamed))
            else reportFailure("renamed op or no upstream stall during dispatch stall");
        assert (!(anyRenamed && outNow > FULL_LEVEL))
            else reportFailure($sformatf("op renamed with %0d ops in flight", outNow));
        assert (!(anyRenamed && serialHeld))
            else reportFailure("op renamed while a serialized op is pending");
        // Serializer phase moves on only when the stage is not stalled
        if (!serialHeld && !expStall) begin
            holdSerial = 1'b0;
        end
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            assert (renamed[i].valid == (pipeOp[i].valid && !expStall && !clear))
                else reportFailure($sformatf("slot %0d valid is %0b", i, renamed[i].valid));
            if (renamed[i].valid) begin
                checkedOps++;
                assert (renamed[i].pc == pipeOp[i].pc && !killed.exists(renamed[i].pc))
                    else reportFailure($sformatf("slot %0d pc %h, expected %h",
                                                 i, renamed[i].pc, pipeOp[i].pc));
                assert (renamed[i].opInfo == pipeOp[i].opInfo
                        && renamed[i].activeListPtr == nextAlPtr)
                    else reportFailure($sformatf("slot %0d op info or list slot %0d, expected %0d",
                                                 i, renamed[i].activeListPtr, nextAlPtr));
                nextAlPtr = nextAlPtr + 1'b1;
                decodeFields(pipeOp[i].opInfo, srcA, srcB, dst);
                if (pipeOp[i].opInfo.readRegA) begin
                    assert (renamed[i].phySrcA == modelMap[srcA])
                        else reportFailure($sformatf("slot %0d source A p%0d, expected p%0d",
                                                     i, renamed[i].phySrcA, modelMap[srcA]));
                end
                if (pipeOp[i].opInfo.readRegB) begin
                    assert (renamed[i].phySrcB == modelMap[srcB])
                        else reportFailure($sformatf("slot %0d source B p%0d, expected p%0d",
                                                     i, renamed[i].phySrcB, modelMap[srcB]));
                end
                if (pipeOp[i].opInfo.serialized) begin
                    assert (outNow == 0 && (!isFence || storeQueueEmpty))
                        else reportFailure("serialized op renamed before older work drained");
                    holdSerial = 1'b1;
                end
                if (pipeOp[i].opInfo.writeReg) begin
                    assert (renamed[i].phyPrevDst == modelMap[dst])
                        else reportFailure($sformatf("slot %0d previous p%0d, expected p%0d",
                                                     i, renamed[i].phyPrevDst, modelMap[dst]));
                    assert (!inUse[renamed[i].phyDst])
                        else reportFailure($sformatf("p%0d allocated while in use",
                                                     renamed[i].phyDst));
                    modelMap[dst] = renamed[i].phyDst;
                    inUse[renamed[i].phyDst] = 1'b1;
                end
                expCommit.valid = 1'b1;
                expCommit.logDst = dst;
                expCommit.phyDst = renamed[i].phyDst;
                expCommit.phyPrevDst = renamed[i].phyPrevDst;
                expCommit.writeReg = pipeOp[i].opInfo.writeReg;
                expectQ.push_back(expCommit);
                outstanding++;
            end
        end
        assert (committed.valid == (commit && outNow > 0))
            else reportFailure($sformatf("commit valid is %0b", committed.valid));
        if (committed.valid) begin
            expCommit = expectQ.pop_front();
            assert (committed.writeReg == expCommit.writeReg)
                else reportFailure("commit writeReg mismatch");
            if (expCommit.writeReg) begin
                assert (committed.logDst == expCommit.logDst
                        && committed.phyDst == expCommit.phyDst
                        && committed.phyPrevDst == expCommit.phyPrevDst)
                    else reportFailure($sformatf("commit r%0d p%0d p%0d, expected r%0d p%0d p%0d",
                        committed.logDst, committed.phyDst, committed.phyPrevDst,
                        expCommit.logDst, expCommit.phyDst, expCommit.phyPrevDst));
                inUse[expCommit.phyPrevDst] = 1'b0;
            end
            outstanding--;
        end
        // Pipeline register contents after the coming edge
        if (clear) begin
            for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
                if (pipeOp[i].valid) begin
                    killed[pipeOp[i].pc] = 1'b1;
                end
                pipeOp[i].valid = 1'b0;
            end
            holdSerial = 1'b0;
        end else if (!expStall) begin
            for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
                pipeOp[i] = decoded[i];
            end
        end
        advance = !upstreamStall || clear;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            resetModel();
        end else begin
            checkCycle();
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic directed;
        logic serialWindow;
        rst = 1'b1;
        decoded = '0;
        clear = 1'b0;
        dispatchStall = 1'b0;
        commit = 1'b0;
        storeQueueEmpty = 1'b1;
        checkedOps = 0;
        nextPc = 32'h1000;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clk);
            #1;
            r = $random(seed);
            // Fill the active list, then clear held groups
            directed = cycle >= 600 && cycle < 700;
            serialWindow = cycle >= 660 && cycle < 680;
            commit = directed ? (cycle >= 680) : r[0];
            dispatchStall = directed ? (cycle >= 680) : (r[4:1] == 4'd0);
            clear = directed ? (cycle == 670 || cycle == 677 || cycle == 695 || cycle == 698)
                             : (r[10:5] == 6'd0);
            if (r[13:11] == 3'd0) begin
                storeQueueEmpty = !storeQueueEmpty;
            end
            if (advance) begin
                makeGroup(!directed, serialWindow);
            end
        end
        @(posedge clk);
        #1;
        if (checkedOps > 100) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Too few renamed ops were seen: %0d", checkedOps);
            $display("RESULT: FAIL");
            $fatal(1, "stimulus did not reach the checks");
        end
    end

endmodule

`default_nettype wire

// File: list.f
renamePkg.sv
renameSerializer.sv
renameMapTable.sv
activeList.sv
renameStage.sv
renameTop.sv
tbRename.sv

// File: Makefile
TOOL     := verilator
TOP      := tbRename
FILELIST := list.f
FLAGS    := --binary --timing --assert -Wno-fatal
BUILD    := obj_dir
LOG      := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
